// ==== kl10Edp.f ====
source/kl10EdpPkg.sv
source/edpBuffer.sv
source/edpApbPort.sv
source/edpAdder.sv
source/edpFastMemory.sv
source/edpDataPath.sv
source/kl10Edp.sv
verif/kl10EdpTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f kl10Edp.f --top-module kl10EdpTb \
  -Mdir obj_dir -o kl10EdpSim

# Simulation status is judged from the log, not the exit code
./obj_dir/kl10EdpSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== source/edpAdder.sv ====
`timescale 1ns/1ps

module edpAdder (
  input  kl10EdpPkg::tWord    aIn,
  input  kl10EdpPkg::tWord    bIn,
  input  kl10EdpPkg::tAluFunc func,
  output kl10EdpPkg::tWord    ad,
  output logic                carryOut
);

  logic             subtract;
  logic             arith;
  kl10EdpPkg::tWord bEff;
  kl10EdpPkg::tWord bitGen;
  kl10EdpPkg::tWord bitProp;
  kl10EdpPkg::tWord sum;
  logic [0:5]       grpGen;
  logic [0:5]       grpProp;
  logic [0:5]       grpCarry;
  logic             arithCarry;

  assign subtract = (func == kl10EdpPkg::aluSub);
  assign arith = (func == kl10EdpPkg::aluAdd) || subtract;
  // A minus B as A plus not B plus one
  assign bEff = subtract ? ~bIn : bIn;
  assign bitGen = aIn & bEff;
  assign bitProp = aIn ^ bEff;

  // Group generate and propagate, bit 5 of each group is its LSB
  always_comb begin
    for (int g = 0; g < 6; g++) begin
      grpGen[g] = 1'b0;
      grpProp[g] = 1'b1;
      for (int i = 5; i >= 0; i--) begin
        grpGen[g] = bitGen[6*g+i] | (bitProp[6*g+i] & grpGen[g]);
        grpProp[g] = grpProp[g] & bitProp[6*g+i];
      end
    end
  end

  // Lookahead stage, each group carry from G and P of lower groups only
  always_comb begin
    for (int g = 0; g < 6; g++) begin
      grpCarry[g] = subtract;
      for (int k = 5; k > g; k--) begin
        grpCarry[g] = grpGen[k] | (grpProp[k] & grpCarry[g]);
      end
    end
    arithCarry = grpGen[0] | (grpProp[0] & grpCarry[0]);
  end

  // Ripple inside each group from its lookahead carry
  always_comb begin
    logic c;
    for (int g = 0; g < 6; g++) begin
      c = grpCarry[g];
      for (int i = 5; i >= 0; i--) begin
        sum[6*g+i] = bitProp[6*g+i] ^ c;
        c = bitGen[6*g+i] | (bitProp[6*g+i] & c);
      end
    end
  end

  always_comb begin
    case (func)
      kl10EdpPkg::aluAdd,
      kl10EdpPkg::aluSub:   ad = sum;
      kl10EdpPkg::aluAnd:   ad = aIn & bIn;
      kl10EdpPkg::aluOr:    ad = aIn | bIn;
      kl10EdpPkg::aluXor:   ad = aIn ^ bIn;
      kl10EdpPkg::aluAndcb: ad = aIn & ~bIn;
      kl10EdpPkg::aluPassA: ad = aIn;
      default:              ad = bIn;
    endcase
  end

  assign carryOut = arith && arithCarry;

endmodule

// ==== source/edpApbPort.sv ====
`timescale 1ns/1ps

module edpApbPort (
  input  logic                                CLK,
  input  logic                                arstN,
  input  logic                                PSEL,
  input  logic                                PENABLE,
  input  logic                                PWRITE,
  input  logic [kl10EdpPkg::apbAddrWidth-1:0] PADDR,
  input  logic [31:0]                         PWDATA,
  output logic [31:0]                         PRDATA,
  output logic                                PREADY,
  output logic                                PSLVERR,
  output logic                                cmdPush,
  output kl10EdpPkg::tCmdEntry                cmdData,
  input  logic                                cmdFull,
  input  logic                                cmdEmpty,
  output logic                                diagPop,
  input  kl10EdpPkg::tWord                    diagData,
  input  logic                                diagEmpty,
  input  logic                                diagFull
);

  logic access;
  logic wrAccess;
  logic rdAccess;
  logic microWrite;
  logic leftRead;

  // Staging literal and the right half of the last popped word
  kl10EdpPkg::tHalf litLeft;
  kl10EdpPkg::tHalf litRight;
  kl10EdpPkg::tHalf rightLatch;

  assign access = PSEL && PENABLE;
  assign wrAccess = access && PWRITE;
  assign rdAccess = access && !PWRITE;
  assign microWrite = wrAccess && (PADDR == kl10EdpPkg::addrMicro);
  assign leftRead = rdAccess && (PADDR == kl10EdpPkg::addrDiagLeft);

  // No wait states
  assign PREADY = access;

  assign cmdPush = microWrite && !cmdFull;
  assign diagPop = leftRead && !diagEmpty;
  // Overflowing write or empty pop
  assign PSLVERR = (microWrite && cmdFull) || (leftRead && diagEmpty);

  always_comb begin
    cmdData.literal = {litLeft, litRight};
    cmdData.micro = kl10EdpPkg::tMicroWord'(PWDATA[25:0]);
  end

  always_comb begin
    PRDATA = '0;
    if (rdAccess) begin
      case (PADDR)
        kl10EdpPkg::addrDiagLeft: begin
          if (!diagEmpty) begin
            PRDATA[17:0] = diagData[0:17];
          end
        end
        kl10EdpPkg::addrDiagRight: PRDATA[17:0] = rightLatch;
        kl10EdpPkg::addrStatus:    PRDATA[3:0] = {diagFull, cmdFull, !diagEmpty, cmdEmpty};
        default:                   PRDATA = '0;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      litLeft <= '0;
      litRight <= '0;
      rightLatch <= '0;
    end else begin
      if (wrAccess && (PADDR == kl10EdpPkg::addrLitLeft)) begin
        litLeft <= PWDATA[17:0];
      end
      if (wrAccess && (PADDR == kl10EdpPkg::addrLitRight)) begin
        litRight <= PWDATA[17:0];
      end
      if (diagPop) begin
        rightLatch <= diagData[18:35];
      end
    end
  end

  // Access phase always follows a setup phase of the same transfer
  apbPhaseOrder: assert property (@(posedge CLK) disable iff (!arstN)
    PENABLE |-> PSEL && $past(PSEL && !PENABLE))
    else $error("PENABLE without a preceding setup phase");

endmodule

// ==== source/edpBuffer.sv ====
`timescale 1ns/1ps

module edpBuffer #(
  parameter type tPayload = logic,
  parameter int  DEPTH    = 4
) (
  input  logic    CLK,
  input  logic    arstN,
  input  logic    push,
  input  tPayload pushData,
  output logic    full,
  input  logic    pop,
  output tPayload popData,
  output logic    empty
);

  typedef logic [$clog2(DEPTH)-1:0]   tPtr;
  typedef logic [$clog2(DEPTH+1)-1:0] tCount;

  tPayload mem [DEPTH];

  tPtr   wrPtr;
  tPtr   rdPtr;
  tCount count;

  assign full = (count == tCount'(DEPTH));
  assign empty = (count == '0);
  // Head entry is visible whenever the buffer holds something
  assign popData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == tPtr'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == tPtr'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer and consumer must honor the flags
  noPushWhenFull: assert property (@(posedge CLK) disable iff (!arstN) push |-> !full)
    else $error("Buffer push while full");
  noPopWhenEmpty: assert property (@(posedge CLK) disable iff (!arstN) pop |-> !empty)
    else $error("Buffer pop while empty");

endmodule

// ==== source/edpDataPath.sv ====
`timescale 1ns/1ps

module edpDataPath (
  input  logic                 CLK,
  input  logic                 arstN,
  input  kl10EdpPkg::tCmdEntry cmdData,
  input  logic                 cmdEmpty,
  output logic                 cmdPop,
  input  logic                 diagFull,
  output logic                 diagPush,
  output kl10EdpPkg::tWord     diagData
);

  kl10EdpPkg::tMicroWord micro;
  kl10EdpPkg::tWord      literal;
  logic                  execute;

  kl10EdpPkg::tWord ar;
  kl10EdpPkg::tWord arx;
  kl10EdpPkg::tWord br;
  kl10EdpPkg::tWord brx;
  kl10EdpPkg::tWord mq;

  kl10EdpPkg::tWord ada;
  kl10EdpPkg::tWord adb;
  kl10EdpPkg::tWord ad;
  logic             adCarry;
  kl10EdpPkg::tWord fmRead;
  kl10EdpPkg::tWord arNext;
  kl10EdpPkg::tWord mqNext;

  assign micro = cmdData.micro;
  assign literal = cmdData.literal;

  // A diagnostic word waits for room in the result buffer
  assign execute = !cmdEmpty && (!micro.diagEn || !diagFull);
  assign cmdPop = execute;
  assign diagPush = execute && micro.diagEn;

  always_comb begin
    case (micro.adaSel)
      kl10EdpPkg::adaAr:  ada = ar;
      kl10EdpPkg::adaArx: ada = arx;
      kl10EdpPkg::adaMq:  ada = mq;
      default:            ada = '0;
    endcase
  end

  always_comb begin
    case (micro.adbSel)
      kl10EdpPkg::adbFm:   adb = fmRead;
      kl10EdpPkg::adbBr:   adb = br;
      kl10EdpPkg::adbBrx2: adb = {br[1:35], brx[0]};
      default:             adb = {ar[2:35], arx[0:1]};
    endcase
  end

  edpAdder adder (
    .aIn      (ada),
    .bIn      (adb),
    .func     (micro.aluFunc),
    .ad       (ad),
    .carryOut (adCarry)
  );

  edpFastMemory fastMemory (
    .CLK        (CLK),
    .arstN      (arstN),
    .addr       (micro.fmAddr),
    .writeLeft  (execute && micro.fmWrite[1]),
    .writeRight (execute && micro.fmWrite[0]),
    .writeData  (ar),
    .readData   (fmRead)
  );

  always_comb begin
    case (micro.arSel)
      kl10EdpPkg::arAd:  arNext = ad;
      kl10EdpPkg::arLit: arNext = literal;
      kl10EdpPkg::arFm:  arNext = fmRead;
      default:           arNext = {ad[18:35], ad[0:17]};
    endcase
  end

  // MQ as universal shift register
  always_comb begin
    case (micro.mqFunc)
      kl10EdpPkg::mqLoad: mqNext = ad;
      kl10EdpPkg::mqShl:  mqNext = {mq[1:35], adCarry};
      kl10EdpPkg::mqShr:  mqNext = {ad[35], mq[0:34]};
      default:            mqNext = mq;
    endcase
  end

  always_comb begin
    case (micro.diagSel)
      kl10EdpPkg::diagAr:  diagData = ar;
      kl10EdpPkg::diagArx: diagData = arx;
      kl10EdpPkg::diagBr:  diagData = br;
      kl10EdpPkg::diagBrx: diagData = brx;
      kl10EdpPkg::diagMq:  diagData = mq;
      kl10EdpPkg::diagFm:  diagData = fmRead;
      kl10EdpPkg::diagAd:  diagData = ad;
      default:             diagData = literal;
    endcase
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ar <= '0;
      arx <= '0;
      br <= '0;
      brx <= '0;
      mq <= '0;
    end else if (execute) begin
      if (micro.arLoad) begin
        ar <= arNext;
      end
      if (micro.arxLoad) begin
        arx <= micro.arxSel ? mq : ad;
      end
      if (micro.brLoad) begin
        br <= ar;
      end
      if (micro.brxLoad) begin
        brx <= arx;
      end
      mq <= mqNext;
    end
  end

  diagPushHasRoom: assert property (@(posedge CLK) disable iff (!arstN) diagPush |-> !diagFull)
    else $error("Diagnostic push while result buffer full");

  // Stalled head entry stays in place until the result buffer drains
  diagStallHolds: assert property (@(posedge CLK) disable iff (!arstN)
    (!cmdEmpty && micro.diagEn && diagFull) |=> (!cmdEmpty && $stable(cmdData)))
    else $error("Stalled micro-word left the command buffer");

endmodule

// ==== source/edpFastMemory.sv ====
`timescale 1ns/1ps

module edpFastMemory (
  input  logic             CLK,
  input  logic             arstN,
  input  logic [3:0]       addr,
  input  logic             writeLeft,
  input  logic             writeRight,
  input  kl10EdpPkg::tWord writeData,
  output kl10EdpPkg::tWord readData
);

  kl10EdpPkg::tWord mem [16];

  assign readData = mem[addr];

  // Halfword write enables
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (writeLeft) begin
        mem[addr][0:17] <= writeData[0:17];
      end
      if (writeRight) begin
        mem[addr][18:35] <= writeData[18:35];
      end
    end
  end

endmodule

// ==== source/kl10Edp.sv ====
`timescale 1ns/1ps

module kl10Edp (
  input  logic                                CLK,
  input  logic                                arstN,
  input  logic                                PSEL,
  input  logic                                PENABLE,
  input  logic                                PWRITE,
  input  logic [kl10EdpPkg::apbAddrWidth-1:0] PADDR,
  input  logic [31:0]                         PWDATA,
  output logic [31:0]                         PRDATA,
  output logic                                PREADY,
  output logic                                PSLVERR
);

  logic                 cmdPush;
  kl10EdpPkg::tCmdEntry cmdPushData;
  logic                 cmdFull;
  logic                 cmdPop;
  kl10EdpPkg::tCmdEntry cmdPopData;
  logic                 cmdEmpty;

  logic                 diagPush;
  kl10EdpPkg::tWord     diagPushData;
  logic                 diagFull;
  logic                 diagPop;
  kl10EdpPkg::tWord     diagPopData;
  logic                 diagEmpty;

  edpApbPort apbPort (
    .CLK       (CLK),
    .arstN     (arstN),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PWRITE    (PWRITE),
    .PADDR     (PADDR),
    .PWDATA    (PWDATA),
    .PRDATA    (PRDATA),
    .PREADY    (PREADY),
    .PSLVERR   (PSLVERR),
    .cmdPush   (cmdPush),
    .cmdData   (cmdPushData),
    .cmdFull   (cmdFull),
    .cmdEmpty  (cmdEmpty),
    .diagPop   (diagPop),
    .diagData  (diagPopData),
    .diagEmpty (diagEmpty),
    .diagFull  (diagFull)
  );

  // Micro-words from the host toward the data path
  edpBuffer #(
    .tPayload (kl10EdpPkg::tCmdEntry),
    .DEPTH    (kl10EdpPkg::cmdDepth)
  ) cmdBuffer (
    .CLK      (CLK),
    .arstN    (arstN),
    .push     (cmdPush),
    .pushData (cmdPushData),
    .full     (cmdFull),
    .pop      (cmdPop),
    .popData  (cmdPopData),
    .empty    (cmdEmpty)
  );

  // Diagnostic words back to the host
  edpBuffer #(
    .tPayload (kl10EdpPkg::tWord),
    .DEPTH    (kl10EdpPkg::diagDepth)
  ) diagBuffer (
    .CLK      (CLK),
    .arstN    (arstN),
    .push     (diagPush),
    .pushData (diagPushData),
    .full     (diagFull),
    .pop      (diagPop),
    .popData  (diagPopData),
    .empty    (diagEmpty)
  );

  edpDataPath dataPath (
    .CLK      (CLK),
    .arstN    (arstN),
    .cmdData  (cmdPopData),
    .cmdEmpty (cmdEmpty),
    .cmdPop   (cmdPop),
    .diagFull (diagFull),
    .diagPush (diagPush),
    .diagData (diagPushData)
  );

endmodule

// ==== source/kl10EdpPkg.sv ====
package kl10EdpPkg;

  // Bit 0 is the most significant bit
  typedef logic [0:35] tWord;
  typedef logic [0:17] tHalf;

  typedef enum logic [1:0] {adaAr, adaArx, adaMq, adaZero} tAdaSel;
  typedef enum logic [1:0] {adbFm, adbBr, adbBrx2, adbArx4} tAdbSel;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluAndcb, aluPassA, aluPassB
  } tAluFunc;

  typedef enum logic [1:0] {arAd, arLit, arFm, arSwap} tArSel;

  // Universal shift register functions for MQ
  typedef enum logic [1:0] {mqLoad, mqShl, mqShr, mqHold} tMqFunc;

  typedef enum logic [2:0] {
    diagAr, diagArx, diagBr, diagBrx, diagMq, diagFm, diagAd, diagLit
  } tDiagSel;

  // fmWrite bit 1 enables the left half, bit 0 the right half
  typedef struct packed {
    tAdaSel      adaSel;
    tAdbSel      adbSel;
    tAluFunc     aluFunc;
    tArSel       arSel;
    logic        arLoad;
    logic        arxSel;
    logic        arxLoad;
    logic        brLoad;
    logic        brxLoad;
    tMqFunc      mqFunc;
    logic [1:0]  fmWrite;
    logic [3:0]  fmAddr;
    logic        diagEn;
    tDiagSel     diagSel;
  } tMicroWord;

  typedef struct packed {
    tWord      literal;
    tMicroWord micro;
  } tCmdEntry;

  localparam int cmdDepth = 8;
  localparam int diagDepth = 4;

  localparam int apbAddrWidth = 8;

  localparam logic [apbAddrWidth-1:0] addrMicro     = 8'h00;
  localparam logic [apbAddrWidth-1:0] addrLitLeft   = 8'h04;
  localparam logic [apbAddrWidth-1:0] addrLitRight  = 8'h08;
  localparam logic [apbAddrWidth-1:0] addrDiagLeft  = 8'h10;
  localparam logic [apbAddrWidth-1:0] addrDiagRight = 8'h14;
  localparam logic [apbAddrWidth-1:0] addrStatus    = 8'h18;

endpackage

// ==== verif/kl10EdpTb.sv ====
`timescale 1ns/1ps

module kl10EdpTb;

  logic                                CLK;
  logic                                arstN;
  logic                                PSEL;
  logic                                PENABLE;
  logic                                PWRITE;
  logic [kl10EdpPkg::apbAddrWidth-1:0] PADDR;
  logic [31:0]                         PWDATA;
  logic [31:0]                         PRDATA;
  logic                                PREADY;
  logic                                PSLVERR;

  // Expectations for the current access phase
  logic        checkRead;
  logic [31:0] expData;
  logic        expSlvErr;

  int dataErrors;
  int slvErrors;
  int otherErrors;

  logic [31:0] lcgState;

  // Reference model state
  kl10EdpPkg::tWord mAr;
  kl10EdpPkg::tWord mArx;
  kl10EdpPkg::tWord mBr;
  kl10EdpPkg::tWord mBrx;
  kl10EdpPkg::tWord mMq;
  kl10EdpPkg::tWord mFm [16];
  kl10EdpPkg::tWord litModel;
  kl10EdpPkg::tWord expQueue [$];

  kl10Edp UUT (
    .CLK     (CLK),
    .arstN   (arstN),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  readValue: assert property (@(posedge CLK) disable iff (!arstN)
    (PSEL && PENABLE && checkRead) |-> (PRDATA == expData))
    else begin
      dataErrors++;
      $display("ERROR at %0t: read of 0x%02h returned 0x%08h, expected 0x%08h",
               $time, $sampled(PADDR), $sampled(PRDATA), $sampled(expData));
    end

  slvErrValue: assert property (@(posedge CLK) disable iff (!arstN)
    (PSEL && PENABLE) |-> (PSLVERR == expSlvErr && PREADY))
    else begin
      slvErrors++;
      $display("ERROR at %0t: access to 0x%02h gave PSLVERR %0b PREADY %0b, expected PSLVERR %0b",
               $time, $sampled(PADDR), $sampled(PSLVERR), $sampled(PREADY),
               $sampled(expSlvErr));
    end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic kl10EdpPkg::tWord randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcgNext();
    lo = lcgNext();
    return {hi, lo[31:28]};
  endfunction

  // Carry out in bit 36, result below
  function automatic logic [36:0] aluModel(input kl10EdpPkg::tWord a,
                                           input kl10EdpPkg::tWord b,
                                           input kl10EdpPkg::tAluFunc f);
    case (f)
      kl10EdpPkg::aluAdd:   return {1'b0, a} + {1'b0, b};
      kl10EdpPkg::aluSub:   return {1'b0, a} + {1'b0, ~b} + 37'd1;
      kl10EdpPkg::aluAnd:   return {1'b0, a & b};
      kl10EdpPkg::aluOr:    return {1'b0, a | b};
      kl10EdpPkg::aluXor:   return {1'b0, a ^ b};
      kl10EdpPkg::aluAndcb: return {1'b0, a & ~b};
      kl10EdpPkg::aluPassA: return {1'b0, a};
      default:              return {1'b0, b};
    endcase
  endfunction

  function automatic kl10EdpPkg::tMicroWord nop();
    kl10EdpPkg::tMicroWord m;
    m = '0;
    m.adbSel = kl10EdpPkg::adbBr;
    m.mqFunc = kl10EdpPkg::mqHold;
    return m;
  endfunction

  task automatic applyMicro(input kl10EdpPkg::tMicroWord m, input kl10EdpPkg::tWord lit);
    kl10EdpPkg::tWord a;
    kl10EdpPkg::tWord b;
    kl10EdpPkg::tWord ad;
    kl10EdpPkg::tWord fmWord;
    kl10EdpPkg::tWord newAr;
    kl10EdpPkg::tWord newMq;
    kl10EdpPkg::tWord diagWord;
    logic [36:0]      aluOut;
    fmWord = mFm[m.fmAddr];
    case (m.adaSel)
      kl10EdpPkg::adaAr:  a = mAr;
      kl10EdpPkg::adaArx: a = mArx;
      kl10EdpPkg::adaMq:  a = mMq;
      default:            a = '0;
    endcase
    case (m.adbSel)
      kl10EdpPkg::adbFm:   b = fmWord;
      kl10EdpPkg::adbBr:   b = mBr;
      kl10EdpPkg::adbBrx2: b = {mBr[1:35], mBrx[0]};
      default:             b = {mAr[2:35], mArx[0:1]};
    endcase
    aluOut = aluModel(a, b, m.aluFunc);
    ad = aluOut[35:0];
    case (m.arSel)
      kl10EdpPkg::arAd:  newAr = ad;
      kl10EdpPkg::arLit: newAr = lit;
      kl10EdpPkg::arFm:  newAr = fmWord;
      default:           newAr = {ad[18:35], ad[0:17]};
    endcase
    case (m.mqFunc)
      kl10EdpPkg::mqLoad: newMq = ad;
      kl10EdpPkg::mqShl:  newMq = {mMq[1:35], aluOut[36]};
      kl10EdpPkg::mqShr:  newMq = {ad[35], mMq[0:34]};
      default:            newMq = mMq;
    endcase
    case (m.diagSel)
      kl10EdpPkg::diagAr:  diagWord = mAr;
      kl10EdpPkg::diagArx: diagWord = mArx;
      kl10EdpPkg::diagBr:  diagWord = mBr;
      kl10EdpPkg::diagBrx: diagWord = mBrx;
      kl10EdpPkg::diagMq:  diagWord = mMq;
      kl10EdpPkg::diagFm:  diagWord = fmWord;
      kl10EdpPkg::diagAd:  diagWord = ad;
      default:             diagWord = lit;
    endcase
    if (m.diagEn) begin
      expQueue.push_back(diagWord);
    end
    // Each source is read before its register is overwritten
    if (m.fmWrite[1]) begin
      mFm[m.fmAddr][0:17] = mAr[0:17];
    end
    if (m.fmWrite[0]) begin
      mFm[m.fmAddr][18:35] = mAr[18:35];
    end
    if (m.brLoad) begin
      mBr = mAr;
    end
    if (m.brxLoad) begin
      mBrx = mArx;
    end
    if (m.arxLoad) begin
      mArx = m.arxSel ? mMq : ad;
    end
    mMq = newMq;
    if (m.arLoad) begin
      mAr = newAr;
    end
  endtask

  // Both APB tasks start and end 2 ns after a rising edge
  task automatic apbWrite(input logic [kl10EdpPkg::apbAddrWidth-1:0] addr,
                          input logic [31:0] data, input logic errExp);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b1;
    PADDR = addr;
    PWDATA = data;
    @(posedge CLK);
    #2;
    PENABLE = 1'b1;
    checkRead = 1'b0;
    expSlvErr = errExp;
    @(posedge CLK);
    #2;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    expSlvErr = 1'b0;
  endtask

  task automatic apbRead(input logic [kl10EdpPkg::apbAddrWidth-1:0] addr,
                         input logic [31:0] expValue, input logic check,
                         input logic errExp, output logic [31:0] rdata);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = addr;
    @(posedge CLK);
    #2;
    PENABLE = 1'b1;
    checkRead = check;
    expData = expValue;
    expSlvErr = errExp;
    @(negedge CLK);
    rdata = PRDATA;
    @(posedge CLK);
    #2;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    checkRead = 1'b0;
    expSlvErr = 1'b0;
  endtask

  task automatic waitStatus(input int bitIdx, input logic value, input string what);
    logic [31:0] st;
    int          tries;
    tries = 0;
    apbRead(kl10EdpPkg::addrStatus, '0, 1'b0, 1'b0, st);
    while (st[bitIdx] != value && tries < 50) begin
      tries++;
      apbRead(kl10EdpPkg::addrStatus, '0, 1'b0, 1'b0, st);
    end
    if (st[bitIdx] != value) begin
      otherErrors++;
      $display("Timed out at %0t waiting for %s", $time, what);
    end
  endtask

  task automatic setLiteral(input kl10EdpPkg::tWord w);
    apbWrite(kl10EdpPkg::addrLitLeft, 32'(w[0:17]), 1'b0);
    apbWrite(kl10EdpPkg::addrLitRight, 32'(w[18:35]), 1'b0);
    litModel = w;
  endtask

  task automatic issue(input kl10EdpPkg::tMicroWord m, input logic errExp);
    apbWrite(kl10EdpPkg::addrMicro, 32'(m), errExp);
    if (!errExp) begin
      applyMicro(m, litModel);
    end
  endtask

  task automatic loadAr(input kl10EdpPkg::tWord w);
    kl10EdpPkg::tMicroWord m;
    setLiteral(w);
    m = nop();
    m.arSel = kl10EdpPkg::arLit;
    m.arLoad = 1'b1;
    issue(m, 1'b0);
  endtask

  task automatic checkDiag();
    kl10EdpPkg::tWord e;
    logic [31:0]      rd;
    waitStatus(1, 1'b1, "result buffer not empty");
    if (expQueue.size() == 0) begin
      otherErrors++;
      $display("A diagnostic word was expected but the model queue is empty");
    end else begin
      e = expQueue.pop_front();
      apbRead(kl10EdpPkg::addrDiagLeft, 32'(e[0:17]), 1'b1, 1'b0, rd);
      apbRead(kl10EdpPkg::addrDiagRight, 32'(e[18:35]), 1'b1, 1'b0, rd);
    end
  endtask

  task automatic probe(input kl10EdpPkg::tDiagSel sel, input logic [3:0] addr);
    kl10EdpPkg::tMicroWord m;
    m = nop();
    m.diagEn = 1'b1;
    m.diagSel = sel;
    m.fmAddr = addr;
    issue(m, 1'b0);
    checkDiag();
  endtask

  initial begin
    kl10EdpPkg::tMicroWord m;
    logic [31:0]           rd;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    arstN = 1'b0;
    checkRead = 1'b0;
    expData = '0;
    expSlvErr = 1'b0;
    dataErrors = 0;
    slvErrors = 0;
    otherErrors = 0;
    lcgState = 32'h67ae;
    mAr = '0;
    mArx = '0;
    mBr = '0;
    mBrx = '0;
    mMq = '0;
    litModel = '0;
    for (int i = 0; i < 16; i++) begin
      mFm[i] = '0;
    end
    repeat (16) @(posedge CLK);
    #2;
    arstN = 1'b1;
    @(posedge CLK);
    #2;

    // Reset state
    apbRead(kl10EdpPkg::addrStatus, 32'h1, 1'b1, 1'b0, rd);
    for (int i = 0; i < 8; i++) begin
      probe(kl10EdpPkg::tDiagSel'(3'(i)), 4'd0);
    end
    for (int a = 1; a < 16; a++) begin
      probe(kl10EdpPkg::diagFm, 4'(a));
    end

    // Literals, BR/BRX copies, ADD, SUB and SWAP
    for (int i = 0; i < 3; i++) begin
      loadAr(randWord());
      m = nop();
      m.aluFunc = kl10EdpPkg::aluPassA;
      m.arxLoad = 1'b1;
      issue(m, 1'b0);
      m = nop();
      m.brLoad = 1'b1;
      m.brxLoad = 1'b1;
      issue(m, 1'b0);
      probe(kl10EdpPkg::diagBrx, 4'd0);
      loadAr(randWord());
      probe(kl10EdpPkg::diagAr, 4'd0);
      probe(kl10EdpPkg::diagAd, 4'd0);
      m = nop();
      m.aluFunc = kl10EdpPkg::aluSub;
      m.diagEn = 1'b1;
      m.diagSel = kl10EdpPkg::diagAd;
      issue(m, 1'b0);
      checkDiag();
      m = nop();
      m.arSel = kl10EdpPkg::arSwap;
      m.arLoad = 1'b1;
      issue(m, 1'b0);
      probe(kl10EdpPkg::diagAr, 4'd0);
    end

    // All adder functions, carry seen through MQ shift left
    for (int f = 0; f < 8; f++) begin
      loadAr(randWord());
      m = nop();
      m.brLoad = 1'b1;
      issue(m, 1'b0);
      loadAr(randWord());
      m = nop();
      m.aluFunc = kl10EdpPkg::tAluFunc'(3'(f));
      m.mqFunc = kl10EdpPkg::mqShl;
      m.diagEn = 1'b1;
      m.diagSel = kl10EdpPkg::diagAd;
      issue(m, 1'b0);
      checkDiag();
      probe(kl10EdpPkg::diagMq, 4'd0);
    end
    m = nop();
    m.aluFunc = kl10EdpPkg::aluXor;
    m.mqFunc = kl10EdpPkg::mqLoad;
    issue(m, 1'b0);
    m.mqFunc = kl10EdpPkg::mqShr;
    issue(m, 1'b0);
    probe(kl10EdpPkg::diagMq, 4'd0);
    m = nop();
    m.adaSel = kl10EdpPkg::adaZero;
    m.aluFunc = kl10EdpPkg::aluPassA;
    issue(m, 1'b0);
    probe(kl10EdpPkg::diagMq, 4'd0);

    // FM halfword writes and the three read paths
    loadAr(randWord());
    m = nop();
    m.fmWrite = 2'b10;
    m.fmAddr = 4'd3;
    issue(m, 1'b0);
    probe(kl10EdpPkg::diagFm, 4'd3);
    loadAr(randWord());
    m.fmWrite = 2'b01;
    issue(m, 1'b0);
    loadAr(randWord());
    m.fmWrite = 2'b11;
    m.fmAddr = 4'd7;
    issue(m, 1'b0);
    probe(kl10EdpPkg::diagFm, 4'd3);
    probe(kl10EdpPkg::diagFm, 4'd7);
    m = nop();
    m.adaSel = kl10EdpPkg::adaZero;
    m.adbSel = kl10EdpPkg::adbFm;
    m.aluFunc = kl10EdpPkg::aluPassB;
    m.fmAddr = 4'd3;
    m.diagEn = 1'b1;
    m.diagSel = kl10EdpPkg::diagAd;
    issue(m, 1'b0);
    checkDiag();
    m = nop();
    m.arSel = kl10EdpPkg::arFm;
    m.arLoad = 1'b1;
    m.fmAddr = 4'd7;
    issue(m, 1'b0);
    probe(kl10EdpPkg::diagAr, 4'd0);

    // Shifted B sources, ARX from AD and from MQ, zero A source
    loadAr(randWord());
    m = nop();
    m.aluFunc = kl10EdpPkg::aluPassA;
    m.arxLoad = 1'b1;
    issue(m, 1'b0);
    probe(kl10EdpPkg::diagArx, 4'd0);
    loadAr(randWord());
    m = nop();
    m.brLoad = 1'b1;
    m.brxLoad = 1'b1;
    issue(m, 1'b0);
    m = nop();
    m.adaSel = kl10EdpPkg::adaZero;
    m.adbSel = kl10EdpPkg::adbBrx2;
    m.diagEn = 1'b1;
    m.diagSel = kl10EdpPkg::diagAd;
    issue(m, 1'b0);
    checkDiag();
    m.adbSel = kl10EdpPkg::adbArx4;
    issue(m, 1'b0);
    checkDiag();
    m = nop();
    m.mqFunc = kl10EdpPkg::mqLoad;
    issue(m, 1'b0);
    m = nop();
    m.arxSel = 1'b1;
    m.arxLoad = 1'b1;
    issue(m, 1'b0);
    probe(kl10EdpPkg::diagArx, 4'd0);

    // Back-pressure: four results fill the buffer, two entries stall
    waitStatus(0, 1'b1, "command buffer empty");
    for (int i = 0; i < 6; i++) begin
      setLiteral(randWord());
      m = nop();
      m.diagEn = 1'b1;
      m.diagSel = kl10EdpPkg::diagLit;
      issue(m, 1'b0);
    end
    waitStatus(3, 1'b1, "result buffer full");
    for (int i = 0; i < 6; i++) begin
      issue(nop(), 1'b0);
    end
    waitStatus(2, 1'b1, "command buffer full");
    // Dropped entry, must never come back
    setLiteral(36'h5a5a5a5a5);
    issue(m, 1'b1);
    while (expQueue.size() > 0) begin
      checkDiag();
    end
    waitStatus(0, 1'b1, "command buffer empty");
    apbRead(kl10EdpPkg::addrDiagLeft, 32'h0, 1'b1, 1'b1, rd);

    waitStatus(1, 1'b0, "result buffer empty");
    $display("Errors: %0d data, %0d PSLVERR, %0d other", dataErrors, slvErrors, otherErrors);
    if (dataErrors == 0 && slvErrors == 0 && otherErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
